//--- Makefile
# Verilator flow for the text line renderer

TOP := text_renderer_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)
	verilator --lint-only -f verilog.f --top-module text_renderer

sim:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "Testbench failed" sim.log; then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- src/char_buffer.sv
// Character buffer, stage 2 of the text renderer
// Host-written line memory of COLS character codes, read at the
// scan column and registered together with the scan position
`timescale 1ns/1ps

module char_buffer #(
    parameter int COLS = 16
) (
    input  logic                       clk,
    input  logic                       rst_l,
    input  logic                       wr_en,
    input  logic [text_pkg::col_w-1:0] wr_addr,
    input  text_pkg::char_t            wr_char,
    input  text_pkg::scan_pos_t        pos,
    output text_pkg::char_pos_t        cpos
);

    // Index width of the line memory
    localparam int addr_w = (COLS > 1) ? $clog2(COLS) : 1;

    text_pkg::char_t mem [COLS];

    logic wr_hit;

    // Drop writes past the end of the line
    assign wr_hit = wr_en && (int'(wr_addr) < COLS);

    // Line memory, cleared to zero which renders blank
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            for (int i = 0; i < COLS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_hit) begin
            mem[wr_addr[addr_w-1:0]] <= wr_char;
        end
    end

    // Character and position move together into stage 3
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            cpos <= '0;
        end else begin
            cpos.pos <= pos;
            cpos.chr <= mem[pos.col[addr_w-1:0]];
        end
    end

endmodule

//--- src/glyph_pixel.sv
// Glyph pixel stage, stage 3 of the text renderer
// Looks up the glyph row of the current character and registers
// the pixel at the current pixel column with its strobes
`timescale 1ns/1ps

module glyph_pixel (
    input  logic                clk,
    input  logic                rst_l,
    input  text_pkg::char_pos_t cpos,
    output text_pkg::pix_out_t  pout
);

    logic [5:0] glyph_row;
    logic [2:0] bit_sel;
    logic       pix_next;

    glyph_rom u_rom (
        .chr (cpos.chr),
        .gy  (cpos.pos.gy),
        .row (glyph_row)
    );

    // Pixel column 0 is the MSB of the row
    assign bit_sel = 3'(text_pkg::glyph_w - 1) - cpos.pos.gx;

    // Idle cycles carry a dark pixel
    assign pix_next = cpos.pos.valid & glyph_row[bit_sel];

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            pout <= '0;
        end else begin
            pout.valid <= cpos.pos.valid;
            pout.last  <= cpos.pos.last;
            pout.pix   <= pix_next;
        end
    end

endmodule

//--- src/glyph_rom.sv
// 6x6 font table
// Maps a character code and a glyph row to six pixel bits, MSB
// leftmost; unsupported codes give an empty row
`timescale 1ns/1ps

module glyph_rom (
    input  text_pkg::char_t chr,
    input  logic [2:0]      gy,
    output logic [5:0]      row
);

    logic [5:0] rows [text_pkg::glyph_h];

    always_comb begin
        case (chr)
            // Period
            8'h2e: rows = '{6'h00, 6'h00, 6'h00, 6'h00, 6'h0c, 6'h0c};
            // Digits
            8'h30: rows = '{6'h1e, 6'h23, 6'h25, 6'h29, 6'h31, 6'h1e};
            8'h31: rows = '{6'h04, 6'h0c, 6'h14, 6'h04, 6'h04, 6'h1f};
            8'h32: rows = '{6'h1e, 6'h21, 6'h01, 6'h1e, 6'h20, 6'h3f};
            8'h33: rows = '{6'h1e, 6'h21, 6'h06, 6'h01, 6'h21, 6'h1e};
            8'h34: rows = '{6'h02, 6'h06, 6'h0a, 6'h12, 6'h3f, 6'h02};
            8'h35: rows = '{6'h3f, 6'h20, 6'h3e, 6'h01, 6'h21, 6'h1e};
            8'h36: rows = '{6'h1e, 6'h20, 6'h3e, 6'h21, 6'h21, 6'h1e};
            8'h37: rows = '{6'h3f, 6'h01, 6'h02, 6'h04, 6'h08, 6'h08};
            8'h38: rows = '{6'h1e, 6'h21, 6'h1e, 6'h21, 6'h21, 6'h1e};
            8'h39: rows = '{6'h1e, 6'h21, 6'h21, 6'h1f, 6'h01, 6'h1e};
            // Colon
            8'h3a: rows = '{6'h00, 6'h08, 6'h00, 6'h00, 6'h08, 6'h00};
            // Letters A to M
            8'h41: rows = '{6'h1e, 6'h21, 6'h21, 6'h3f, 6'h21, 6'h21};
            8'h42: rows = '{6'h3e, 6'h21, 6'h3e, 6'h21, 6'h21, 6'h3e};
            8'h43: rows = '{6'h1e, 6'h21, 6'h20, 6'h20, 6'h21, 6'h1e};
            8'h44: rows = '{6'h3c, 6'h22, 6'h21, 6'h21, 6'h22, 6'h3c};
            8'h45: rows = '{6'h3f, 6'h20, 6'h3c, 6'h20, 6'h20, 6'h3f};
            8'h46: rows = '{6'h3f, 6'h20, 6'h3e, 6'h20, 6'h20, 6'h20};
            8'h47: rows = '{6'h1e, 6'h21, 6'h20, 6'h27, 6'h21, 6'h1e};
            8'h48: rows = '{6'h21, 6'h21, 6'h3f, 6'h21, 6'h21, 6'h21};
            8'h49: rows = '{6'h0e, 6'h04, 6'h04, 6'h04, 6'h04, 6'h0e};
            8'h4a: rows = '{6'h07, 6'h02, 6'h02, 6'h22, 6'h22, 6'h1c};
            8'h4b: rows = '{6'h22, 6'h24, 6'h38, 6'h24, 6'h22, 6'h21};
            8'h4c: rows = '{6'h20, 6'h20, 6'h20, 6'h20, 6'h20, 6'h3f};
            8'h4d: rows = '{6'h21, 6'h33, 6'h2d, 6'h21, 6'h21, 6'h21};
            // Letters N to Z
            8'h4e: rows = '{6'h21, 6'h31, 6'h29, 6'h25, 6'h23, 6'h21};
            8'h4f: rows = '{6'h1e, 6'h21, 6'h21, 6'h21, 6'h21, 6'h1e};
            8'h50: rows = '{6'h3e, 6'h21, 6'h21, 6'h3e, 6'h20, 6'h20};
            8'h51: rows = '{6'h1e, 6'h21, 6'h21, 6'h25, 6'h23, 6'h1e};
            8'h52: rows = '{6'h3e, 6'h21, 6'h21, 6'h3e, 6'h22, 6'h21};
            8'h53: rows = '{6'h1f, 6'h20, 6'h1e, 6'h01, 6'h01, 6'h3e};
            8'h54: rows = '{6'h3e, 6'h08, 6'h08, 6'h08, 6'h08, 6'h08};
            8'h55: rows = '{6'h21, 6'h21, 6'h21, 6'h21, 6'h21, 6'h1e};
            8'h56: rows = '{6'h21, 6'h21, 6'h21, 6'h21, 6'h12, 6'h0c};
            8'h57: rows = '{6'h21, 6'h21, 6'h21, 6'h21, 6'h2d, 6'h12};
            8'h58: rows = '{6'h21, 6'h12, 6'h0c, 6'h0c, 6'h12, 6'h21};
            8'h59: rows = '{6'h22, 6'h14, 6'h08, 6'h08, 6'h08, 6'h08};
            8'h5a: rows = '{6'h3f, 6'h02, 6'h04, 6'h08, 6'h10, 6'h3f};
            // Blank cell for anything else
            default: rows = '{default: 6'h00};
        endcase
    end

    // Only the requested row leaves the table
    always_comb begin
        if (int'(gy) < text_pkg::glyph_h) begin
            row = rows[gy];
        end else begin
            row = '0;
        end
    end

endmodule

//--- src/scan_counter.sv
// Scan counter, stage 1 of the text renderer
// Walks glyph row, character column and pixel column in raster
// order after a start pulse, one position per clock
`timescale 1ns/1ps

module scan_counter #(
    parameter int COLS = 16
) (
    input  logic                clk,
    input  logic                rst_l,
    input  logic                start,
    output logic                busy,
    output text_pkg::scan_pos_t pos
);

    text_pkg::scan_state_t      state;
    logic [2:0]                 gx;
    logic [text_pkg::col_w-1:0] col;
    logic [2:0]                 gy;

    logic gx_end;
    logic col_end;
    logic gy_end;
    logic frame_end;

    // Limits of the three nested counters
    assign gx_end  = (gx == 3'(text_pkg::glyph_w - 1));
    assign col_end = (col == text_pkg::col_w'(COLS - 1));
    assign gy_end  = (gy == 3'(text_pkg::glyph_h - 1));

    // Final position of the frame
    assign frame_end = (state == text_pkg::scan_run) && gx_end && col_end && gy_end;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state <= text_pkg::scan_idle;
            gx    <= '0;
            col   <= '0;
            gy    <= '0;
        end else begin
            case (state)
                text_pkg::scan_idle: begin
                    // Counters already sit at zero here
                    if (start) begin
                        state <= text_pkg::scan_run;
                    end
                end
                text_pkg::scan_run: begin
                    // Start is ignored while running
                    if (frame_end) begin
                        state <= text_pkg::scan_idle;
                    end
                    // Pixel column carries into character column,
                    // which carries into glyph row; all wrap to zero
                    if (gx_end) begin
                        gx <= '0;
                        if (col_end) begin
                            col <= '0;
                            if (gy_end) begin
                                gy <= '0;
                            end else begin
                                gy <= gy + 3'd1;
                            end
                        end else begin
                            col <= col + 1'b1;
                        end
                    end else begin
                        gx <= gx + 3'd1;
                    end
                end
                default: state <= text_pkg::scan_idle;
            endcase
        end
    end

    assign busy = (state == text_pkg::scan_run);

    // Position is valid for every running cycle
    always_comb begin
        pos.valid = busy;
        pos.last  = frame_end;
        pos.col   = col;
        pos.gx    = gx;
        pos.gy    = gy;
    end

endmodule

//--- src/text_pkg.sv
// Text overlay shared definitions
// Font geometry, scan state and the structs passed between
// the three pipeline stages of the line renderer
package text_pkg;

    // Glyph cell size in pixels
    localparam int glyph_w = 6;
    localparam int glyph_h = 6;

    // Character column index width, caps the line at 256 cells
    localparam int col_w = 8;

    // ASCII character code
    typedef logic [7:0] char_t;

    // Stage 1 control state
    typedef enum logic {
        scan_idle = 1'b0,
        scan_run  = 1'b1
    } scan_state_t;

    // Scan position out of stage 1
    typedef struct packed {
        logic             valid;
        logic             last;
        logic [col_w-1:0] col;
        // Pixel column within the glyph
        logic [2:0]       gx;
        // Glyph row
        logic [2:0]       gy;
    } scan_pos_t;

    // Position plus the character found at it, out of stage 2
    typedef struct packed {
        scan_pos_t pos;
        char_t     chr;
    } char_pos_t;

    // Final pixel out of stage 3
    typedef struct packed {
        logic valid;
        logic last;
        logic pix;
    } pix_out_t;

endpackage

//--- src/text_renderer.sv
// Text line renderer
// Turns a host-written line of characters into a serial stream of
// monochrome pixels through a three-stage pipeline:
// scan position, character fetch, glyph pixel
`timescale 1ns/1ps

module text_renderer #(
    parameter int COLS = 16
) (
    input  logic                       clk,
    input  logic                       rst_l,
    input  logic                       wr_en,
    input  logic [text_pkg::col_w-1:0] wr_addr,
    input  text_pkg::char_t            wr_char,
    input  logic                       start,
    output logic                       busy,
    output logic                       pix_valid,
    output logic                       pix,
    output logic                       pix_last
);

    text_pkg::scan_pos_t pos;
    text_pkg::char_pos_t cpos;
    text_pkg::pix_out_t  pout;

    scan_counter #(
        .COLS (COLS)
    ) u_scan (
        .clk   (clk),
        .rst_l (rst_l),
        .start (start),
        .busy  (busy),
        .pos   (pos)
    );

    char_buffer #(
        .COLS (COLS)
    ) u_buf (
        .clk     (clk),
        .rst_l   (rst_l),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_char (wr_char),
        .pos     (pos),
        .cpos    (cpos)
    );

    glyph_pixel u_pix (
        .clk   (clk),
        .rst_l (rst_l),
        .cpos  (cpos),
        .pout  (pout)
    );

    // Pixel stream outputs
    assign pix_valid = pout.valid;
    assign pix       = pout.pix;
    assign pix_last  = pout.last;

endmodule

//--- testbench/text_renderer_tb.sv
// Testbench for the text line renderer
// Writes lines of text into the character buffer, runs scans and
// checks every pixel against a reference copy of the 6x6 font
`timescale 1ns/1ps

module text_renderer_tb;

    localparam int COLS      = 8;
    localparam int COL_BITS  = $clog2(COLS);
    localparam int FRAME_PIX = 36 * COLS;
    localparam int TIMEOUT   = 4 * FRAME_PIX + 100;

    logic                       clk;
    logic                       rst_l;
    logic                       wr_en;
    logic [text_pkg::col_w-1:0] wr_addr;
    text_pkg::char_t            wr_char;
    logic                       start;
    logic                       busy;
    logic                       pix_valid;
    logic                       pix;
    logic                       pix_last;

    // Mirror of what was written into the line buffer
    text_pkg::char_t line_chars [COLS];

    string       test_name = "none";
    int          error_count = 0;
    int          total_pixels = 0;
    int          frames_done = 0;
    int          busy_falls = 0;
    int          last_frame_ones = 0;
    logic [31:0] lfsr_state;
    // Set when a wait runs out of cycles
    logic        timed_out = 1'b0;

    // Expected raster position of the next pixel
    logic [2:0]          exp_gx = '0;
    logic [COL_BITS-1:0] exp_col = '0;
    logic [2:0]          exp_gy = '0;
    int                  frame_pix = 0;
    int                  frame_ones = 0;
    logic                in_frame = 1'b0;
    logic                busy_prev = 1'b0;

    text_renderer #(
        .COLS (COLS)
    ) dut (
        .clk       (clk),
        .rst_l     (rst_l),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_char   (wr_char),
        .start     (start),
        .busy      (busy),
        .pix_valid (pix_valid),
        .pix       (pix),
        .pix_last  (pix_last)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reference font, rows top to bottom, MSB is the leftmost pixel
    function automatic logic [5:0] ref_glyph_row(input text_pkg::char_t c,
                                                 input logic [2:0] gy);
        logic [35:0] g;
        logic [35:0] shifted;
        case (c)
            8'h2e: g = {6'h00, 6'h00, 6'h00, 6'h00, 6'h0c, 6'h0c};
            8'h30: g = {6'h1e, 6'h23, 6'h25, 6'h29, 6'h31, 6'h1e};
            8'h31: g = {6'h04, 6'h0c, 6'h14, 6'h04, 6'h04, 6'h1f};
            8'h32: g = {6'h1e, 6'h21, 6'h01, 6'h1e, 6'h20, 6'h3f};
            8'h33: g = {6'h1e, 6'h21, 6'h06, 6'h01, 6'h21, 6'h1e};
            8'h34: g = {6'h02, 6'h06, 6'h0a, 6'h12, 6'h3f, 6'h02};
            8'h35: g = {6'h3f, 6'h20, 6'h3e, 6'h01, 6'h21, 6'h1e};
            8'h36: g = {6'h1e, 6'h20, 6'h3e, 6'h21, 6'h21, 6'h1e};
            8'h37: g = {6'h3f, 6'h01, 6'h02, 6'h04, 6'h08, 6'h08};
            8'h38: g = {6'h1e, 6'h21, 6'h1e, 6'h21, 6'h21, 6'h1e};
            8'h39: g = {6'h1e, 6'h21, 6'h21, 6'h1f, 6'h01, 6'h1e};
            8'h3a: g = {6'h00, 6'h08, 6'h00, 6'h00, 6'h08, 6'h00};
            8'h41: g = {6'h1e, 6'h21, 6'h21, 6'h3f, 6'h21, 6'h21};
            8'h42: g = {6'h3e, 6'h21, 6'h3e, 6'h21, 6'h21, 6'h3e};
            8'h43: g = {6'h1e, 6'h21, 6'h20, 6'h20, 6'h21, 6'h1e};
            8'h44: g = {6'h3c, 6'h22, 6'h21, 6'h21, 6'h22, 6'h3c};
            8'h45: g = {6'h3f, 6'h20, 6'h3c, 6'h20, 6'h20, 6'h3f};
            8'h46: g = {6'h3f, 6'h20, 6'h3e, 6'h20, 6'h20, 6'h20};
            8'h47: g = {6'h1e, 6'h21, 6'h20, 6'h27, 6'h21, 6'h1e};
            8'h48: g = {6'h21, 6'h21, 6'h3f, 6'h21, 6'h21, 6'h21};
            8'h49: g = {6'h0e, 6'h04, 6'h04, 6'h04, 6'h04, 6'h0e};
            8'h4a: g = {6'h07, 6'h02, 6'h02, 6'h22, 6'h22, 6'h1c};
            8'h4b: g = {6'h22, 6'h24, 6'h38, 6'h24, 6'h22, 6'h21};
            8'h4c: g = {6'h20, 6'h20, 6'h20, 6'h20, 6'h20, 6'h3f};
            8'h4d: g = {6'h21, 6'h33, 6'h2d, 6'h21, 6'h21, 6'h21};
            8'h4e: g = {6'h21, 6'h31, 6'h29, 6'h25, 6'h23, 6'h21};
            8'h4f: g = {6'h1e, 6'h21, 6'h21, 6'h21, 6'h21, 6'h1e};
            8'h50: g = {6'h3e, 6'h21, 6'h21, 6'h3e, 6'h20, 6'h20};
            8'h51: g = {6'h1e, 6'h21, 6'h21, 6'h25, 6'h23, 6'h1e};
            8'h52: g = {6'h3e, 6'h21, 6'h21, 6'h3e, 6'h22, 6'h21};
            8'h53: g = {6'h1f, 6'h20, 6'h1e, 6'h01, 6'h01, 6'h3e};
            8'h54: g = {6'h3e, 6'h08, 6'h08, 6'h08, 6'h08, 6'h08};
            8'h55: g = {6'h21, 6'h21, 6'h21, 6'h21, 6'h21, 6'h1e};
            8'h56: g = {6'h21, 6'h21, 6'h21, 6'h21, 6'h12, 6'h0c};
            8'h57: g = {6'h21, 6'h21, 6'h21, 6'h21, 6'h2d, 6'h12};
            8'h58: g = {6'h21, 6'h12, 6'h0c, 6'h0c, 6'h12, 6'h21};
            8'h59: g = {6'h22, 6'h14, 6'h08, 6'h08, 6'h08, 6'h08};
            8'h5a: g = {6'h3f, 6'h02, 6'h04, 6'h08, 6'h10, 6'h3f};
            // Anything unsupported is a blank cell
            default: g = '0;
        endcase
        // Bring the wanted row up to the top six bits
        shifted = g << (6 * int'(gy));
        return shifted[35:30];
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic take_random_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(take_random_bit());
        end
        return v;
    endfunction

    // Index 0..37 into digits, letters, period and colon
    function automatic text_pkg::char_t char_from_index(input int idx);
        if (idx < 10) begin
            return 8'(48 + idx);
        end else if (idx < 36) begin
            return 8'(65 + idx - 10);
        end else if (idx == 36) begin
            return 8'h2e;
        end else begin
            return 8'h3a;
        end
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic finish_run();
        $display("%0d pixels checked, %0d errors", total_pixels, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic write_char(input logic [7:0] addr, input text_pkg::char_t c);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_char <= c;
        @(posedge clk);
        wr_en <= 1'b0;
        line_chars[addr[COL_BITS-1:0]] = c;
    endtask

    task automatic write_line(input string s);
        for (int i = 0; i < COLS; i++) begin
            write_char(8'(i), (s.len() > i) ? s[i] : 8'h00);
        end
    endtask

    // Returns just after the edge that samples start
    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_frames(input int target);
        int cycles;
        cycles = 0;
        while (frames_done < target && !timed_out) begin
            if (cycles >= TIMEOUT) begin
                $display("Timeout in %s: pix_last never arrived", test_name);
                error_count++;
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // One full frame with latency and pixel count checks
    task automatic run_frame();
        int cycles;
        int pixels_before;
        int target;
        pixels_before = total_pixels;
        target = frames_done + 1;
        pulse_start();
        cycles = 0;
        while (!pix_valid && !timed_out) begin
            if (cycles >= TIMEOUT) begin
                $display("Timeout in %s: pix_valid never rose after start", test_name);
                error_count++;
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        if (!timed_out) begin
            check_value({test_name, " latency"}, 3, cycles);
            wait_frames(target);
        end
        if (!timed_out) begin
            check_value({test_name, " pixel count"}, FRAME_PIX, total_pixels - pixels_before);
        end
    endtask

    // Compare each pixel with the reference, mid-cycle where outputs are settled
    always @(negedge clk) begin : compare_pixels
        logic [5:0] exp_row;
        int         exp_pix;
        if (rst_l) begin
            if (busy_prev && !busy) begin
                busy_falls++;
            end
            busy_prev = busy;
            if (pix_valid) begin
                exp_row = ref_glyph_row(line_chars[exp_col], exp_gy);
                exp_pix = int'(exp_row[3'd5 - exp_gx]);
                check_value($sformatf("%s pixel %0d", test_name, frame_pix),
                            exp_pix, int'(pix));
                check_value($sformatf("%s pix_last at %0d", test_name, frame_pix),
                            int'(frame_pix == FRAME_PIX - 1), int'(pix_last));
                frame_pix++;
                total_pixels++;
                frame_ones += int'(pix);
                // Raster order: gx fastest, then column, then glyph row
                if (exp_gx == 3'd5) begin
                    exp_gx = 3'd0;
                    if (exp_col == COL_BITS'(COLS - 1)) begin
                        exp_col = '0;
                        exp_gy = (exp_gy == 3'd5) ? 3'd0 : exp_gy + 3'd1;
                    end else begin
                        exp_col = exp_col + 1'b1;
                    end
                end else begin
                    exp_gx = exp_gx + 3'd1;
                end
                if (pix_last) begin
                    frames_done++;
                    last_frame_ones = frame_ones;
                    frame_ones = 0;
                    frame_pix = 0;
                    exp_gx = '0;
                    exp_col = '0;
                    exp_gy = '0;
                    in_frame = 1'b0;
                end else begin
                    in_frame = 1'b1;
                end
            end else begin
                if (in_frame) begin
                    $display("Pixel stream gap in %s: pix_valid dropped before pix_last",
                             test_name);
                    error_count++;
                    in_frame = 1'b0;
                end
                check_value({test_name, " idle pix"}, 0, int'(pix));
                check_value({test_name, " idle pix_last"}, 0, int'(pix_last));
            end
        end
    end

    initial begin : main_sequence
        int falls_before;
        int pixels_before;
        int target;
        rst_l      = 1'b0;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_char    = '0;
        start      = 1'b0;
        lfsr_state = 32'hd6f3_54f9;
        for (int i = 0; i < COLS; i++) begin
            line_chars[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst_l <= 1'b1;
        @(negedge clk);

        // Outputs quiet out of reset, untouched buffer is blank
        test_name = "reset";
        check_value("reset busy", 0, int'(busy));
        check_value("reset pix_valid", 0, int'(pix_valid));
        check_value("reset pix_last", 0, int'(pix_last));
        check_value("reset pix", 0, int'(pix));
        run_frame();
        check_value("reset foreground pixels", 0, last_frame_ones);

        test_name = "known text";
        write_line("HELLO:42");
        run_frame();

        // Lower case, space and 0xff next to supported codes
        test_name = "unsupported codes";
        write_char(8'd0, 8'h61);
        write_char(8'd1, 8'h48);
        write_char(8'd2, 8'h20);
        write_char(8'd3, 8'h31);
        write_char(8'd4, 8'hff);
        write_char(8'd5, 8'h5a);
        write_char(8'd6, 8'h7a);
        write_char(8'd7, 8'h2e);
        run_frame();

        // Second start in mid frame must be ignored
        test_name = "start while busy";
        falls_before = busy_falls;
        pixels_before = total_pixels;
        target = frames_done + 1;
        pulse_start();
        repeat (100) @(negedge clk);
        check_value("start while busy mid busy", 1, int'(busy));
        pulse_start();
        wait_frames(target);
        repeat (20) @(negedge clk);
        check_value("start while busy pixel count", FRAME_PIX, total_pixels - pixels_before);
        check_value("start while busy falls", 1, busy_falls - falls_before);
        check_value("start while busy idle", 0, int'(busy));

        // Random supported text, two frames back to back per fill
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < COLS; i++) begin
                write_char(8'(i), char_from_index(random_bits(6) % 38));
            end
            for (int r = 0; r < 2; r++) begin
                test_name = $sformatf("random fill %0d frame %0d", f, r);
                run_frame();
            end
        end

        finish_run();
    end

endmodule

//--- verilog.f
src/text_pkg.sv
src/scan_counter.sv
src/char_buffer.sv
src/glyph_rom.sv
src/glyph_pixel.sv
src/text_renderer.sv
testbench/text_renderer_tb.sv
